// ==== Makefile ====
# Verilator build and run of the output buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_out_buffer
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
PASS_STR  ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
out_buffer_pkg.sv
out_bank_ram.sv
out_read_selector.sv
out_write_loader.sv
out_fifo.sv
out_buffer_top.sv
tb_out_buffer.sv

// ==== out_bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// one bank: simple dual-port ram, sync write, async gated read
////////////////////////////////////////////////////////////////////////////

module out_bank_ram #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                      wrclk,
  input  wire                      rst,
  input  wire                      wr_en,
  input  wire [AW-1:0]             wa,
  input  wire out_buffer_pkg::hd_word_t din,
  input  wire                      rd,
  input  wire [AW-1:0]             ra,
  output out_buffer_pkg::hd_word_t dout
);

  // address width from depth, at least one bit
  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // storage, one word per row
  out_buffer_pkg::hd_word_t mem [FIFO_DEPTH];

  // write port on the decoder clock
  // writes held off while reset is asserted
  always_ff @(posedge wrclk) begin
    if (rst && wr_en) begin
      mem[wa] <= din;
    end
  end

  // async read, zero when not selected
  // lets the selector merge banks with a plain or
  assign dout = rd ? mem[ra] : '0;

endmodule

`default_nettype wire

// ==== out_buffer_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared types and default sizes of the output buffer
////////////////////////////////////////////////////////////////////////////

package out_buffer_pkg;

  // hard-decision word width
  localparam int HDDW = 32;

  // one hard-decision output word
  typedef logic [HDDW-1:0] hd_word_t;

  // output cycle counter, frames up to 255 words
  typedef logic [7:0] cycle_cnt_t;

  // read engine states
  typedef enum logic {
    read_idle,    // waiting for rd_en
    read_active   // frame being streamed
  } read_state_t;

  // default sizes for the top level
  localparam int DEF_KB             = 4;   // number of banks
  localparam int DEF_FIFO_DEPTH     = 8;   // rows per frame
  localparam int DEF_MAX_OUT_CYCLES = 30;  // words per frame, <= KB*FIFO_DEPTH

  // refill request raised on word MAX_OUT_CYCLES-REFILL_LEAD
  localparam int REFILL_LEAD = 3;

endpackage

`default_nettype wire

// ==== out_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// output buffer top: write loader + output fifo
////////////////////////////////////////////////////////////////////////////

module out_buffer_top #(
  parameter int KB             = out_buffer_pkg::DEF_KB,
  parameter int FIFO_DEPTH     = out_buffer_pkg::DEF_FIFO_DEPTH,
  parameter int MAX_OUT_CYCLES = out_buffer_pkg::DEF_MAX_OUT_CYCLES
) (
  input  wire                                    rdclk,
  input  wire                                    wrclk,
  input  wire                                    rst,
  input  wire                                    row_valid,
  input  wire out_buffer_pkg::hd_word_t [KB-1:0] row_data,
  input  wire                                    rd_en,
  output out_buffer_pkg::hd_word_t               hd_out,
  output logic                                   datavalid,
  output logic                                   refill_req,
  output logic                                   frame_loaded
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // loader to bank write port, wrclk domain
  logic                                   wr_en;
  logic [AW-1:0]                          wa;
  out_buffer_pkg::hd_word_t [KB-1:0]      wr_data;

  // decoded rows in, one row per strobe
  out_write_loader #(
    .KB         (KB),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_loader (
    .wrclk        (wrclk),
    .rst          (rst),
    .row_valid    (row_valid),
    .row_data     (row_data),
    .wr_en        (wr_en),
    .wa           (wa),
    .wr_data      (wr_data),
    .frame_loaded (frame_loaded)
  );

  // banks plus read engine, words out on rdclk
  out_fifo #(
    .KB             (KB),
    .FIFO_DEPTH     (FIFO_DEPTH),
    .MAX_OUT_CYCLES (MAX_OUT_CYCLES)
  ) u_fifo (
    .rdclk      (rdclk),
    .wrclk      (wrclk),
    .rst        (rst),
    .rd_en      (rd_en),
    .wr_en      (wr_en),
    .wa         (wa),
    .wr_data    (wr_data),
    .hd_out     (hd_out),
    .datavalid  (datavalid),
    .refill_req (refill_req)
  );

endmodule

`default_nettype wire

// ==== out_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// output fifo controller, read side on rdclk
////////////////////////////////////////////////////////////////////////////

module out_fifo #(
  parameter int KB             = 4,
  parameter int FIFO_DEPTH     = 8,
  parameter int MAX_OUT_CYCLES = 30
) (
  input  wire                                    rdclk,
  input  wire                                    wrclk,
  input  wire                                    rst,
  input  wire                                    rd_en,
  input  wire                                    wr_en,
  input  wire [AW-1:0]                           wa,
  input  wire out_buffer_pkg::hd_word_t [KB-1:0] wr_data,
  output out_buffer_pkg::hd_word_t               hd_out,
  output logic                                   datavalid,
  output logic                                   refill_req
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // count of the last word in a frame
  localparam out_buffer_pkg::cycle_cnt_t LAST_CNT =
    out_buffer_pkg::cycle_cnt_t'(MAX_OUT_CYCLES - 1);

  // count on which the refill request goes out
  localparam out_buffer_pkg::cycle_cnt_t REFILL_CNT =
    out_buffer_pkg::cycle_cnt_t'(MAX_OUT_CYCLES - out_buffer_pkg::REFILL_LEAD);

  out_buffer_pkg::read_state_t state;
  out_buffer_pkg::read_state_t state_nxt;
  out_buffer_pkg::cycle_cnt_t  cycle_count;
  out_buffer_pkg::cycle_cnt_t  cycle_nxt;

  // registered read strobe into the selector
  logic rd_strobe;

  // bank side signals
  wire out_buffer_pkg::hd_word_t [KB-1:0] bank_dout;
  logic [KB-1:0]                          bank_rd;
  logic [KB-1:0][AW-1:0]                  bank_ra;

  ////////////////////////////////////////////////////////////////////////////
  // read state machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge rdclk) begin
    if (!rst) begin
      state       <= out_buffer_pkg::read_idle;
      cycle_count <= '0;
      rd_strobe   <= 1'b0;
      datavalid   <= 1'b0;
    end else begin
      state       <= state_nxt;
      cycle_count <= cycle_nxt;
      // both are rd_en one cycle late
      rd_strobe   <= rd_en;
      datavalid   <= rd_en;
    end
  end

  always_comb begin
    state_nxt = state;
    cycle_nxt = '0;
    case (state)
      out_buffer_pkg::read_idle: begin
        // count held at 0 so word 0 shows right after the start edge
        if (rd_en) begin
          state_nxt = out_buffer_pkg::read_active;
        end
      end
      out_buffer_pkg::read_active: begin
        if (cycle_count == LAST_CNT) begin
          // frame done, back to back if rd_en still high
          state_nxt = rd_en ? out_buffer_pkg::read_active : out_buffer_pkg::read_idle;
        end else begin
          // runs to the end of the frame even if rd_en drops
          cycle_nxt = cycle_count + 1'b1;
        end
      end
      default: begin
        state_nxt = out_buffer_pkg::read_idle;
      end
    endcase
  end

  // refill request while the third-last word is out
  assign refill_req = (state == out_buffer_pkg::read_active) && (cycle_count == REFILL_CNT);

  ////////////////////////////////////////////////////////////////////////////
  // bank array and read selector
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < KB; k++) begin : g_bank
    // bank k takes word k of every row
    out_bank_ram #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) u_bank (
      .wrclk (wrclk),
      .rst   (rst),
      .wr_en (wr_en),
      .wa    (wa),
      .din   (wr_data[k]),
      .rd    (bank_rd[k]),
      .ra    (bank_ra[k]),
      .dout  (bank_dout[k])
    );
  end

  out_read_selector #(
    .KB         (KB),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_selector (
    .cycle_count (cycle_count),
    .rd_enable   (rd_strobe),
    .bank_dout   (bank_dout),
    .bank_rd     (bank_rd),
    .bank_ra     (bank_ra),
    .hd_out      (hd_out)
  );

endmodule

`default_nettype wire

// ==== out_read_selector.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// read selector: cycle number -> bank strobe + row address
////////////////////////////////////////////////////////////////////////////

module out_read_selector #(
  parameter int KB         = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  wire out_buffer_pkg::cycle_cnt_t          cycle_count,
  input  wire                                      rd_enable,
  input  wire out_buffer_pkg::hd_word_t [KB-1:0]   bank_dout,
  output logic [KB-1:0]                            bank_rd,
  output logic [KB-1:0][AW-1:0]                    bank_ra,
  output out_buffer_pkg::hd_word_t                 hd_out
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // bank count in counter width
  localparam out_buffer_pkg::cycle_cnt_t KB_C = out_buffer_pkg::cycle_cnt_t'(KB);

  out_buffer_pkg::cycle_cnt_t bank_idx;  // word c -> bank c mod KB
  out_buffer_pkg::cycle_cnt_t row_idx;   // word c -> row c div KB

  assign bank_idx = cycle_count % KB_C;
  assign row_idx  = cycle_count / KB_C;

  // one-hot strobe, only while the read is enabled
  // same row address broadcast to all banks
  always_comb begin
    for (int k = 0; k < KB; k++) begin
      bank_rd[k] = rd_enable && (bank_idx == out_buffer_pkg::cycle_cnt_t'(k));
      bank_ra[k] = row_idx[AW-1:0];
    end
  end

  // unselected banks output zero, so or them together
  always_comb begin
    hd_out = '0;
    for (int k = 0; k < KB; k++) begin
      hd_out = hd_out | bank_dout[k];
    end
  end

endmodule

`default_nettype wire

// ==== out_write_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// write-side loader on the decoder clock
////////////////////////////////////////////////////////////////////////////

module out_write_loader #(
  parameter int KB         = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  wire                                    wrclk,
  input  wire                                    rst,
  input  wire                                    row_valid,
  input  wire out_buffer_pkg::hd_word_t [KB-1:0] row_data,
  output logic                                   wr_en,
  output logic [AW-1:0]                          wa,
  output out_buffer_pkg::hd_word_t [KB-1:0]      wr_data,
  output logic                                   frame_loaded
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  // address of the last row in a frame
  localparam logic [AW-1:0] LAST_ROW = AW'(FIFO_DEPTH - 1);

  // row counter, next row to be written
  logic [AW-1:0] row_addr;

  // control: strobe, frame flag, row counter
  always_ff @(posedge wrclk) begin
    if (!rst) begin
      row_addr     <= '0;
      wr_en        <= 1'b0;
      frame_loaded <= 1'b0;
    end else begin
      // one write strobe per accepted row, one cycle later
      wr_en        <= row_valid;
      // whole frame in the banks once the last row goes in
      frame_loaded <= row_valid && (row_addr == LAST_ROW);
      if (row_valid) begin
        // wrap back to row 0 for the next frame
        row_addr <= (row_addr == LAST_ROW) ? '0 : row_addr + 1'b1;
      end
    end
  end

  // payload: row data and its address, held for the write edge
  always_ff @(posedge wrclk) begin
    if (row_valid) begin
      wa      <= row_addr;
      wr_data <= row_data;
    end
  end

endmodule

`default_nettype wire

// ==== tb_out_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_out_buffer;

  localparam int KB             = out_buffer_pkg::DEF_KB;
  localparam int FIFO_DEPTH     = out_buffer_pkg::DEF_FIFO_DEPTH;
  localparam int MAX_OUT_CYCLES = out_buffer_pkg::DEF_MAX_OUT_CYCLES;

  // refill goes out three words before the frame ends
  localparam int REFILL_IDX = MAX_OUT_CYCLES - 3;

  // polling limit for every wait loop, in clock cycles
  localparam int WAIT_LIMIT = 50;

  localparam integer SEED_BASE = 32'h998d_dc26;
  localparam int     NUM_TESTS = 3;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table: name, seed offset, back-to-back frames
  ////////////////////////////////////////////////////////////////////////////

  string test_name   [NUM_TESTS] = '{"single_frame", "back_to_back", "reload_frame"};
  int    seed_offset [NUM_TESTS] = '{0, 1, 2};
  int    frame_count [NUM_TESTS] = '{1, 2, 1};

  // dut ports
  logic                              rdclk;
  logic                              wrclk;
  logic                              rst;
  logic                              row_valid;
  out_buffer_pkg::hd_word_t [KB-1:0] row_data;
  logic                              rd_en;
  out_buffer_pkg::hd_word_t          hd_out;
  logic                              datavalid;
  logic                              refill_req;
  logic                              frame_loaded;

  // reference model, index row*KB + bank
  out_buffer_pkg::hd_word_t model [KB*FIFO_DEPTH];

  integer seed;
  int     error_count;
  int     load_pulses;

  out_buffer_top u_out_buffer_top (
    .rdclk        (rdclk),
    .wrclk        (wrclk),
    .rst          (rst),
    .row_valid    (row_valid),
    .row_data     (row_data),
    .rd_en        (rd_en),
    .hd_out       (hd_out),
    .datavalid    (datavalid),
    .refill_req   (refill_req),
    .frame_loaded (frame_loaded)
  );

  // read clock 8 ns, write clock 10 ns
  always #4 rdclk = ~rdclk;
  always #5 wrclk = ~wrclk;

  // count every wrclk cycle with frame_loaded high
  always @(negedge wrclk) begin
    if (frame_loaded === 1'b1) begin
      load_pulses++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %h, actual %h", what, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    error_count++;
  endtask

  // sync reset held for two read clocks
  task automatic reset_dut();
    rst = 1'b0;
    repeat (2) @(posedge rdclk);
    @(negedge rdclk);
    rst = 1'b1;
  endtask

  // nothing may move before the first row or rd_en
  task automatic check_quiet(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge rdclk);
      check_value({name, " datavalid"}, 32'd0, datavalid);
      check_value({name, " refill_req"}, 32'd0, refill_req);
      check_value({name, " frame_loaded"}, 32'd0, frame_loaded);
    end
  endtask

  // write one frame of rows, fill the model and watch frame_loaded
  task automatic load_frame(input int idx);
    int waited;
    seed = SEED_BASE + seed_offset[idx];
    for (int r = 0; r < FIFO_DEPTH; r++) begin
      @(negedge wrclk);
      // no pulse before the last row has gone in
      check_value({test_name[idx], " frame_loaded early"}, 32'd0, frame_loaded);
      row_valid = 1'b1;
      for (int k = 0; k < KB; k++) begin
        model[r*KB + k] = $random(seed);
        row_data[k]     = model[r*KB + k];
      end
    end
    @(negedge wrclk);
    row_valid = 1'b0;
    row_data  = '0;
    waited    = 0;
    while (frame_loaded !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge wrclk);
      waited++;
    end
    if (frame_loaded !== 1'b1) begin
      report_error($sformatf("no frame_loaded pulse within %0d cycles in test %s",
                             WAIT_LIMIT, test_name[idx]));
    end else begin
      // one cycle wide, then quiet; last bank write also lands here
      repeat (3) begin
        @(negedge wrclk);
        check_value({test_name[idx], " frame_loaded width"}, 32'd0, frame_loaded);
      end
    end
  endtask

  // hold rd_en for the table's frame count and check every word
  task automatic read_frames(input int idx);
    int          total;
    int          waited;
    int          word_idx;
    int          bank;
    int          addr;
    int          refills;
    logic [31:0] expected;
    total   = MAX_OUT_CYCLES * frame_count[idx];
    refills = 0;
    @(negedge rdclk);
    rd_en  = 1'b1;
    waited = 0;
    @(negedge rdclk);
    while (datavalid !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge rdclk);
      waited++;
    end
    if (datavalid !== 1'b1) begin
      report_error($sformatf("datavalid never rose within %0d cycles in test %s",
                             WAIT_LIMIT, test_name[idx]));
      rd_en = 1'b0;
    end else begin
      for (int j = 0; j < total; j++) begin
        // word c sits in bank c mod KB at row c div KB
        word_idx = j % MAX_OUT_CYCLES;
        bank     = word_idx % KB;
        addr     = word_idx / KB;
        expected = model[addr*KB + bank];
        // no gap allowed, also across the frame boundary
        check_value($sformatf("%s datavalid %0d", test_name[idx], j), 32'd1, datavalid);
        check_value($sformatf("%s word %0d", test_name[idx], j), expected, hd_out);
        check_value($sformatf("%s refill_req %0d", test_name[idx], j),
                    {31'd0, word_idx == REFILL_IDX}, refill_req);
        if (refill_req === 1'b1) begin
          refills++;
        end
        // last word on the output, let go of rd_en
        if (j == total - 1) begin
          rd_en = 1'b0;
        end
        @(negedge rdclk);
      end
      check_value({test_name[idx], " refill count"}, frame_count[idx], refills);
      check_value({test_name[idx], " datavalid after end"}, 32'd0, datavalid);
      check_value({test_name[idx], " refill_req after end"}, 32'd0, refill_req);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rdclk       = 1'b0;
    wrclk       = 1'b0;
    rst         = 1'b0;
    row_valid   = 1'b0;
    row_data    = '0;
    rd_en       = 1'b0;
    error_count = 0;
    load_pulses = 0;
    seed        = SEED_BASE;

    reset_dut();
    check_quiet("after_reset", 6);

    // each entry rewrites the banks, so stale words would show up here
    for (int t = 0; t < NUM_TESTS; t++) begin
      load_frame(t);
      read_frames(t);
    end

    // exactly one pulse per loaded frame
    check_value("frame_loaded pulse count", NUM_TESTS, load_pulses);

    $display("tests: %0d, errors: %0d", NUM_TESTS, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
